//--- filelist.f
design/refcount_pkg.sv
design/period_if.sv
design/pps_edge_detect.sv
design/period_counter.sv
design/frame_packer.sv
design/byte_fifo.sv
design/fx2_fifo_writer.sv
design/ref_counter_top.sv
bench/tb_clk_gen.sv
bench/ref_counter_props.sv
bench/tb_ref_counter.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the reference counter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ref_counter -f filelist.f

out=$(./obj_dir/Vtb_ref_counter || true)
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
	exit 0
fi
exit 1

//--- bench/tb_ref_counter.sv
// testbench for the frequency reference counter
// random pps periods and FX2 full bursts with frames checked against a period model

`timescale 1ns/1ns

module tb_ref_counter import refcount_pkg::*; ();

	localparam count_t MIN_C = 32'd60;
	localparam count_t MAX_C = 32'd140;
	localparam int     NPER  = 34;  // 1 + 12 + 12 + 9 periods

	logic FX2_CLK, reset_i, one_pps_i;
	logic [2:0] fx2_flags_i;
	byte_t fx2_fd_o;
	logic fx2_slwr_o;
	logic [1:0] led_o;

	int periods [NPER];      // pregenerated pulse spacing
	count_t exp_cnt [$];     // expected count per serial number
	byte_t frame_buf [$];    // bytes of the frame being collected
	int errors = 0, err_mark = 0, tests = 0, frames = 0, dropped = 0;
	int next_sn = 0, pulses = 0, cyc = 0, last_edge = 0, pidx = 0, wd_cycles = 0;
	logic allow_gap = 1'b0;  // stall test tolerates skipped serials
	logic prev_strobe = 1'b0;

	tb_clk_gen #(.RESET_CYCLES(8)) u_clk (.FX2_CLK(FX2_CLK), .reset_o(reset_i));

	ref_counter_top #(.MIN_COUNT(MIN_C), .MAX_COUNT(MAX_C), .FIFO_DEPTH(16)) uut (
		.FX2_CLK     (FX2_CLK),
		.reset_i     (reset_i),
		.one_pps_i   (one_pps_i),
		.fx2_flags_i (fx2_flags_i),
		.fx2_fd_o    (fx2_fd_o),
		.fx2_slwr_o  (fx2_slwr_o),
		.led_o       (led_o)
	);

	always @(posedge FX2_CLK) cyc <= cyc + 1;  // cycle stamp for edge spacing

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		$display("MISMATCH %0t %s expected %0h got %0h", $time, name, exp, got);
		errors++;
	endtask

	// compare a complete frame with the model entry for its serial number
	task automatic check_frame();
		int sn;
		count_t cnt, exp;
		byte_t st;
		sn  = {frame_buf[2], frame_buf[3]};
		cnt = {frame_buf[4], frame_buf[5], frame_buf[6], frame_buf[7]};
		frames++;
		if (frame_buf[0] !== SYNC_BYTE) begin
			report_mismatch("sync byte", 32'(SYNC_BYTE), 32'(frame_buf[0]));
		end
		if (sn < next_sn || sn >= exp_cnt.size()) begin
			$display("ERROR %0t: frame serial %0d is out of order or was never measured", $time, sn);
			errors++;
		end else begin
			if (sn != next_sn) begin
				if (!allow_gap) report_mismatch("serial number", 32'(next_sn), 32'(sn));
				dropped += sn - next_sn;  // whole frames skipped
			end
			next_sn = sn + 1;
			exp = exp_cnt[sn];
			st = '0;
			st[FLAG_SHORT] = (exp < MIN_C);
			st[FLAG_LONG]  = (exp > MAX_C);
			if (frame_buf[1] !== st) report_mismatch("status byte", 32'(st), 32'(frame_buf[1]));
			if (cnt !== exp) report_mismatch("count", exp, cnt);
		end
	endtask

	// bus monitor sampled mid cycle
	always @(negedge FX2_CLK) begin
		if (!reset_i) begin
			if (led_o[0] !== !fx2_flags_i[2]) begin
				report_mismatch("led_o[0]", 32'(!fx2_flags_i[2]), 32'(led_o[0]));
			end
			if (!fx2_slwr_o) begin
				if (!fx2_flags_i[2]) begin
					$display("ERROR %0t: fx2_slwr_o low while the FX2 is full", $time);
					errors++;
				end
				if (prev_strobe) begin
					$display("ERROR %0t: fx2_slwr_o low for two cycles in a row", $time);
					errors++;
				end
				if (pulses < 2) begin
					$display("ERROR %0t: byte written before the second reference pulse", $time);
					errors++;
				end
				frame_buf.push_back(fx2_fd_o);
				if (frame_buf.size() == FRAME_BYTES) begin
					check_frame();
					frame_buf.delete();
				end
			end
			prev_strobe = ~fx2_slwr_o;
		end
	end

	// mode 0 free flow, 1 short full bursts, 2 full for the whole period
	task automatic run_periods(input int n, input int mode);
		int p, bstart, blen;
		logic exp_led;
		for (int k = 0; k < n; k++) begin
			p = periods[pidx];
			pidx++;
			blen = 0;
			bstart = 0;
			if (mode == 1) begin
				blen   = $urandom_range(p / 4, 1);  // short enough to drain within the period
				bstart = $urandom_range(p - blen, 0);
			end
			for (int i = 0; i < p; i++) begin
				@(posedge FX2_CLK);
				if (i == 0) begin
					if (pulses > 0) exp_cnt.push_back(count_t'(cyc - last_edge));  // edge to edge
					last_edge = cyc;
					pulses++;
				end
				one_pps_i <= (i < 2);  // two cycle wide pulse
				fx2_flags_i[2] <= (mode == 2) ? 1'b0
					: !(mode == 1 && i >= bstart && i < bstart + blen);
			end
			exp_led = 1'b0;
			if (exp_cnt.size() > 0) exp_led = (exp_cnt[$] < MIN_C) || (exp_cnt[$] > MAX_C);
			if (led_o[1] !== exp_led) report_mismatch("led_o[1]", 32'(exp_led), 32'(led_o[1]));
		end
	endtask

	// wait for every measured period to come out or give up
	task automatic drain_frames();
		int n;
		n = 0;
		fx2_flags_i[2] <= 1'b1;
		while (next_sn < exp_cnt.size() && n < 400) begin
			@(posedge FX2_CLK);
			n++;
		end
		if (next_sn < exp_cnt.size() || frame_buf.size() != 0) begin
			$display("ERROR %0t: %0d frames still missing after the drain timeout", $time,
				exp_cnt.size() - next_sn);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("test %0d %s: %s (%0d errors)", tests, name,
			(errors == err_mark) ? "ok" : "errors found", errors - err_mark);
		err_mark = errors;
	endtask

	initial begin
		int sum;
		sum = 0;
		one_pps_i   = 1'b0;
		fx2_flags_i = 3'b111;  // not full
		void'($urandom(32'he9fd));
		for (int i = 0; i < NPER; i++) begin
			periods[i] = $urandom_range(200, 40);
			sum += periods[i];
		end
		wd_cycles = sum * 2 + 2000;
		@(negedge reset_i);

		repeat (20) @(posedge FX2_CLK);  // idle bus after reset
		if (fx2_slwr_o !== 1'b1) report_mismatch("fx2_slwr_o", 32'd1, 32'(fx2_slwr_o));
		if (fx2_fd_o !== 8'h00) report_mismatch("fx2_fd_o", 32'd0, 32'(fx2_fd_o));
		if (led_o !== 2'b00) report_mismatch("led_o", 32'd0, 32'(led_o));
		run_periods(1, 0);  // first pulse only arms the counter
		if (frames != 0) begin
			$display("ERROR %0t: frame seen after a single reference pulse", $time);
			errors++;
		end
		finish_test("reset");
		run_periods(12, 0);
		drain_frames();
		finish_test("no back-pressure");
		run_periods(12, 1);
		drain_frames();
		finish_test("full bursts");
		allow_gap = 1'b1;
		run_periods(5, 2);  // FX2 full long enough to overflow the byte fifo
		run_periods(4, 0);
		drain_frames();
		if (dropped == 0) begin
			$display("ERROR %0t: no frame was dropped during the long stall", $time);
			errors++;
		end
		finish_test("long stall");

		$display("summary: %0d tests, %0d frames, %0d dropped, %0d errors", tests, frames, dropped,
			errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// watchdog scaled to the pregenerated periods
	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge FX2_CLK);
		$display("ERROR %0t: watchdog expired after %0d cycles", $time, wd_cycles);
		$display("tests failed");
		$finish;
	end

endmodule

//--- bench/ref_counter_props.sv
// bound checks on the packer and FX2 writer handshakes
// attached to the top level, where both sides of each handshake are visible

`timescale 1ns/1ns

module ref_counter_props #(
	parameter int FREE_W = 5
) (
	input logic              FX2_CLK,
	input logic              reset_i,
	input logic              pk_wr,        // packer write strobe
	input logic [FREE_W-1:0] fifo_free,    // free slots seen by the packer
	input logic [2:0]        fx2_flags_i,
	input logic              fx2_slwr_o
);

	// packer never pushes into a full byte fifo
	a_no_write_when_full: assert property (@(posedge FX2_CLK) disable iff (reset_i)
		pk_wr |-> (fifo_free != '0))
		else $error("packer wrote while the byte fifo had no room");

	// no strobe while the FX2 reports full
	a_no_strobe_when_full: assert property (@(posedge FX2_CLK) disable iff (reset_i)
		!fx2_slwr_o |-> fx2_flags_i[2])
		else $error("slwr strobed while the FX2 was full");

	a_single_strobe: assert property (@(posedge FX2_CLK) disable iff (reset_i)
		!fx2_slwr_o |=> fx2_slwr_o)  // one cycle wide strobes
		else $error("slwr held low for two cycles");

endmodule

bind ref_counter_top ref_counter_props #(.FREE_W(FREE_W)) u_props (
	.FX2_CLK     (FX2_CLK),
	.reset_i     (reset_i),
	.pk_wr       (pk_wr),
	.fifo_free   (fifo_free),
	.fx2_flags_i (fx2_flags_i),
	.fx2_slwr_o  (fx2_slwr_o)
);

//--- bench/tb_clk_gen.sv
// testbench clock and reset
// 10 ns FX2_CLK, reset held high for the first cycles

`timescale 1ns/1ns

module tb_clk_gen #(
	parameter int RESET_CYCLES = 8
) (
	output logic FX2_CLK,
	output logic reset_o
);

	initial begin
		FX2_CLK = 1'b0;
		forever #5 FX2_CLK = ~FX2_CLK;  // 100 MHz
	end

	initial begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge FX2_CLK);
		reset_o <= 1'b0;  // released on an edge like the other inputs
	end

endmodule

//--- design/ref_counter_top.sv
// frequency reference counter top level
// 1 pps gated count of FX2_CLK, framed and streamed into the FX2 slave fifo

`timescale 1ns/1ns

module ref_counter_top import refcount_pkg::*; #(
	parameter count_t MIN_COUNT  = 32'd23_990_000,  // acceptance window, low end
	parameter count_t MAX_COUNT  = 32'd24_010_000,  // acceptance window, high end
	parameter int     FIFO_DEPTH = 16               // byte fifo depth, power of two
) (
	input  logic       FX2_CLK,
	input  logic       reset_i,
	input  logic       one_pps_i,    // reference pulse
	input  logic [2:0] fx2_flags_i,  // FX2 fifo flags, bit 2 not full
	output byte_t      fx2_fd_o,     // FX2 fifo data
	output logic       fx2_slwr_o,   // FX2 write strobe, active low
	output logic [1:0] led_o         // [1] period error, [0] FX2 full
);

	localparam int FREE_W = $clog2(FIFO_DEPTH) + 1;

	logic              gate;
	byte_t             pk_data;
	logic              pk_wr;
	logic              frame_err;
	logic [FREE_W-1:0] fifo_free;
	byte_t             fifo_data;
	logic              fifo_empty;
	logic              fifo_rd;

	period_if per_if ();  // counter to packer

	pps_edge_detect u_edge (
		.FX2_CLK (FX2_CLK),
		.reset_i (reset_i),
		.pps_i   (one_pps_i),
		.gate_o  (gate)
	);

	period_counter #(.MIN_COUNT(MIN_COUNT), .MAX_COUNT(MAX_COUNT)) u_count (
		.FX2_CLK (FX2_CLK),
		.reset_i (reset_i),
		.gate_i  (gate),
		.per_o   (per_if.producer)
	);

	frame_packer #(.FIFO_DEPTH(FIFO_DEPTH)) u_pack (
		.FX2_CLK     (FX2_CLK),
		.reset_i     (reset_i),
		.per_i       (per_if.consumer),
		.free_i      (fifo_free),
		.wr_data_o   (pk_data),
		.wr_en_o     (pk_wr),
		.frame_err_o (frame_err)
	);

	byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.FX2_CLK   (FX2_CLK),
		.reset_i   (reset_i),
		.wr_data_i (pk_data),
		.wr_en_i   (pk_wr),
		.rd_en_i   (fifo_rd),
		.rd_data_o (fifo_data),
		.empty_o   (fifo_empty),
		.free_o    (fifo_free)
	);

	fx2_fifo_writer u_usb (
		.FX2_CLK     (FX2_CLK),
		.reset_i     (reset_i),
		.rd_data_i   (fifo_data),
		.empty_i     (fifo_empty),
		.rd_en_o     (fifo_rd),
		.fx2_flags_i (fx2_flags_i),
		.fx2_fd_o    (fx2_fd_o),
		.fx2_slwr_o  (fx2_slwr_o)
	);

	assign led_o = {frame_err, ~fx2_flags_i[2]};  // red lights while the FX2 is full

endmodule

//--- design/fx2_fifo_writer.sv
// fx2 slave fifo writer
// pulls bytes from the byte fifo and strobes them into the FX2 while it has room

`timescale 1ns/1ns

module fx2_fifo_writer import refcount_pkg::*; (
	input  logic       FX2_CLK,
	input  logic       reset_i,
	input  byte_t      rd_data_i,    // arrives the cycle after rd_en_o
	input  logic       empty_i,
	output logic       rd_en_o,
	input  logic [2:0] fx2_flags_i,  // bit 2 is the FX2 full flag, active low
	output byte_t      fx2_fd_o,
	output logic       fx2_slwr_o    // active low write strobe
);

	localparam int FULL_N_BIT = 2;

	logic  room;      // FX2 has space
	logic  fetch_q;   // read issued, data lands this cycle
	logic  hold_q;    // byte parked on the bus
	byte_t fd_q;

	assign room = fx2_flags_i[FULL_N_BIT];

	// one byte in flight: fetch only when nothing is pending
	assign rd_en_o = ~fetch_q & ~hold_q & ~empty_i & room;

	always_ff @(posedge FX2_CLK) begin
		if (reset_i) begin
			fetch_q <= 1'b0;
			hold_q  <= 1'b0;
			fd_q    <= '0;  // bus idles at zero
		end else begin
			fetch_q <= rd_en_o;
			if (fetch_q) begin
				fd_q   <= rd_data_i;  // capture from fifo read register
				hold_q <= 1'b1;
			end else if (hold_q && room) begin
				hold_q <= 1'b0;  // strobe went out this cycle
			end
		end
	end

	// strobe follows the live full flag so a write never hits a full FX2
	// after a write hold_q drops and the refetch takes a cycle, so slwr never sits low twice
	assign fx2_slwr_o = ~(hold_q & room);
	assign fx2_fd_o   = fd_q;

endmodule

//--- design/byte_fifo.sv
// single clock byte fifo
// circular buffer with occupancy count, reports free space to the packer

`timescale 1ns/1ns

module byte_fifo import refcount_pkg::*; #(
	parameter int FIFO_DEPTH = 16  // power of two
) (
	input  logic  FX2_CLK,
	input  logic  reset_i,
	input  byte_t wr_data_i,
	input  logic  wr_en_i,
	input  logic  rd_en_i,
	output byte_t rd_data_o,                      // valid the cycle after rd_en_i
	output logic  empty_o,
	output logic  [$clog2(FIFO_DEPTH):0] free_o   // slots left
);

	localparam int AW = $clog2(FIFO_DEPTH);

	byte_t         mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr_q;
	logic [AW-1:0] rd_ptr_q;
	logic [AW:0]   used_q;   // bytes stored
	logic          do_wr;
	logic          do_rd;

	assign do_wr = wr_en_i & (used_q != (AW+1)'(FIFO_DEPTH));  // full write ignored
	assign do_rd = rd_en_i & (used_q != '0);                   // empty read ignored

	always_ff @(posedge FX2_CLK) begin
		if (reset_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			used_q   <= '0;
		end else begin
			if (do_wr) wr_ptr_q <= wr_ptr_q + 1'b1;  // pointers wrap at depth
			if (do_rd) rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   used_q <= used_q + 1'b1;
				2'b01:   used_q <= used_q - 1'b1;
				default: used_q <= used_q;  // both or neither
			endcase
		end
	end

	// storage and read register
	always_ff @(posedge FX2_CLK) begin
		if (do_wr) mem[wr_ptr_q] <= wr_data_i;
		if (do_rd) rd_data_o <= mem[rd_ptr_q];
	end

	assign empty_o = (used_q == '0);
	assign free_o  = (AW+1)'(FIFO_DEPTH) - used_q;

endmodule

//--- design/frame_packer.sv
// frame packer
// turns each finished period into an eight byte frame and pushes it into the byte fifo

`timescale 1ns/1ns

module frame_packer import refcount_pkg::*; #(
	parameter int FIFO_DEPTH = 16  // depth of the byte fifo behind us
) (
	input  logic FX2_CLK,
	input  logic reset_i,
	period_if.consumer per_i,                        // finished periods
	input  logic [$clog2(FIFO_DEPTH):0] free_i,      // free slots in the byte fifo
	output byte_t wr_data_o,
	output logic  wr_en_o,
	output logic  frame_err_o                        // last period was out of window
);

	localparam int FREE_W = $clog2(FIFO_DEPTH) + 1;

	packer_state_t state_q;
	sernum_t       sernum_q;   // serial for the next measured period
	logic [2:0]    idx_q;      // byte index inside the frame

	// frame snapshot, payload only
	sernum_t frm_sn_q;
	count_t  frm_cnt_q;
	logic    frm_short_q;
	logic    frm_long_q;
	byte_t   status;

	// serial counts every measured period, dropped or not
	always_ff @(posedge FX2_CLK) begin
		if (reset_i) begin
			sernum_q    <= '0;
			frame_err_o <= 1'b0;
		end else if (per_i.valid) begin
			sernum_q    <= sernum_q + sernum_t'(1);
			frame_err_o <= per_i.short_err | per_i.long_err;  // led follows every period
		end
	end

	// snapshot taken only when idle; a period arriving mid frame is lost
	always_ff @(posedge FX2_CLK) begin
		if (state_q == IDLE && per_i.valid) begin
			frm_sn_q    <= sernum_q;
			frm_cnt_q   <= per_i.count;
			frm_short_q <= per_i.short_err;
			frm_long_q  <= per_i.long_err;
		end
	end

	always_ff @(posedge FX2_CLK) begin
		if (reset_i) begin
			state_q <= IDLE;
			idx_q   <= '0;
		end else begin
			case (state_q)
				IDLE: if (per_i.valid) state_q <= CHECK;
				CHECK: begin
					idx_q <= '0;
					if (free_i >= FREE_W'(FRAME_BYTES)) state_q <= EMIT;  // whole frame fits
					else state_q <= IDLE;                                 // drop it
				end
				EMIT: begin
					idx_q <= idx_q + 3'd1;
					if (idx_q == 3'(FRAME_BYTES - 1)) state_q <= IDLE;  // last byte out
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// status byte, unused bits zero
	always_comb begin
		status             = '0;
		status[FLAG_SHORT] = frm_short_q;
		status[FLAG_LONG]  = frm_long_q;
	end

	assign wr_en_o = (state_q == EMIT);  // one byte per cycle while emitting

	// byte select, msb first for the multi byte fields
	always_comb begin
		case (idx_q)
			3'(IDX_SYNC):   wr_data_o = SYNC_BYTE;
			3'(IDX_STATUS): wr_data_o = status;
			3'(IDX_SN_HI):  wr_data_o = frm_sn_q[15:8];
			3'(IDX_SN_LO):  wr_data_o = frm_sn_q[7:0];
			3'(IDX_CNT_3):  wr_data_o = frm_cnt_q[31:24];
			3'(IDX_CNT_2):  wr_data_o = frm_cnt_q[23:16];
			3'(IDX_CNT_1):  wr_data_o = frm_cnt_q[15:8];
			default:        wr_data_o = frm_cnt_q[7:0];
		endcase
	end

endmodule

//--- design/period_counter.sv
// period counter
// counts FX2_CLK cycles between gate pulses and checks each period against the window

`timescale 1ns/1ns

module period_counter import refcount_pkg::*; #(
	parameter count_t MIN_COUNT = 32'd23_990_000,  // shortest accepted period
	parameter count_t MAX_COUNT = 32'd24_010_000   // longest accepted period
) (
	input  logic FX2_CLK,
	input  logic reset_i,
	input  logic gate_i,          // one cycle gate from the edge detector
	period_if.producer per_o      // finished period out
);

	count_t cnt_q;    // cycles since the last gate
	logic   armed_q;  // set once the first gate has been seen

	// free running counter, restarted by every gate
	// after the gate cycle it reads 1, so at the next gate it equals the distance
	always_ff @(posedge FX2_CLK) begin
		if (reset_i) begin
			cnt_q <= '0;
		end else if (gate_i) begin
			cnt_q <= count_t'(1);
		end else if (cnt_q != '1) begin  // saturate, never wrap
			cnt_q <= cnt_q + count_t'(1);
		end
	end

	// first gate after reset only opens the measurement
	always_ff @(posedge FX2_CLK) begin
		if (reset_i) begin
			armed_q <= 1'b0;
		end else if (gate_i) begin
			armed_q <= 1'b1;
		end
	end

	// valid strobe, one cycle after the closing gate
	always_ff @(posedge FX2_CLK) begin
		if (reset_i) begin
			per_o.valid <= 1'b0;
		end else begin
			per_o.valid <= gate_i & armed_q;
		end
	end

	// latch count and window flags, held until the next period closes
	always_ff @(posedge FX2_CLK) begin
		if (gate_i && armed_q) begin
			per_o.count     <= cnt_q;
			per_o.short_err <= (cnt_q < MIN_COUNT);
			per_o.long_err  <= (cnt_q > MAX_COUNT);
		end
	end

endmodule

//--- design/pps_edge_detect.sv
// reference edge detect
// brings the async 1 pps input into the FX2_CLK domain, one gate pulse per rising edge

`timescale 1ns/1ns

module pps_edge_detect (
	input  logic FX2_CLK,
	input  logic reset_i,
	input  logic pps_i,    // asynchronous 1 pps reference
	output logic gate_o    // one cycle pulse per rising edge
);

	logic [1:0] sync_q;  // two flop synchronizer, [0] sees the pin
	logic       edge_q;  // last synchronized level

	// synchronizer chain
	always_ff @(posedge FX2_CLK) begin
		if (reset_i) begin
			sync_q <= 2'b00;
		end else begin
			sync_q <= {sync_q[0], pps_i};  // shift toward [1]
		end
	end

	// remember the previous level so a high pps is only seen once
	always_ff @(posedge FX2_CLK) begin
		if (reset_i) begin
			edge_q <= 1'b0;
		end else begin
			edge_q <= sync_q[1];
		end
	end

	// registered pulse, low to high on the synchronized line
	always_ff @(posedge FX2_CLK) begin
		if (reset_i) begin
			gate_o <= 1'b0;
		end else begin
			gate_o <= sync_q[1] & ~edge_q;
		end
	end

	// a pulse wider than one cycle still gives a single gate,
	// edge_q follows sync_q[1] so the and term drops after one clock
	// pulses narrower than a clock period may be missed entirely

endmodule

//--- design/period_if.sv
// period handoff from the counter to the frame packer
// count and flags hold steady from one valid strobe to the next

`timescale 1ns/1ns

interface period_if import refcount_pkg::*; ();

	count_t count;      // cycles in the finished period
	logic   valid;      // one cycle strobe per finished period
	logic   short_err;  // count below MIN_COUNT
	logic   long_err;   // count above MAX_COUNT

	// counter side
	modport producer (output count, output valid, output short_err, output long_err);

	// packer side
	modport consumer (input count, input valid, input short_err, input long_err);

endinterface

//--- design/refcount_pkg.sv
// shared types and frame layout for the frequency reference counter
// widths, frame constants and the packer state encoding

package refcount_pkg;

	// cycle count of one reference period, saturates at all ones
	typedef logic [31:0] count_t;

	// frame serial number, wraps after 65535
	typedef logic [15:0] sernum_t;

	// one byte on the fifo and on the fx2 data bus
	typedef logic [7:0] byte_t;

	// frame layout
	localparam int    FRAME_BYTES = 8;      // sync, status, sernum x2, count x4
	localparam byte_t SYNC_BYTE   = 8'hA5;  // first byte of every frame

	// status byte bit positions, remaining bits are zero
	localparam int FLAG_SHORT = 0;  // period below the window
	localparam int FLAG_LONG  = 1;  // period above the window

	// byte positions inside a frame
	localparam int IDX_SYNC   = 0;
	localparam int IDX_STATUS = 1;
	localparam int IDX_SN_HI  = 2;
	localparam int IDX_SN_LO  = 3;
	localparam int IDX_CNT_3  = 4;  // count msb first
	localparam int IDX_CNT_2  = 5;
	localparam int IDX_CNT_1  = 6;
	localparam int IDX_CNT_0  = 7;

	// packer fsm
	typedef enum logic [1:0] {
		IDLE,   // waiting for a finished period
		CHECK,  // looking at fifo free space
		EMIT    // pushing the eight frame bytes
	} packer_state_t;

endpackage
